// File: Bender.yml
package:
  name: naval_engine

sources:
  # package first, then the RTL bottom up
  - logic/naval_pkg.sv
  - logic/turn_sequencer.sv
  - logic/grid_store.sv
  - logic/shot_resolver.sv
  - logic/score_keeper.sv
  - logic/naval_engine.sv
  - target: test
    files:
      - testbench/tb_naval_engine.sv

// File: build.f
logic/naval_pkg.sv
logic/turn_sequencer.sv
logic/grid_store.sv
logic/shot_resolver.sv
logic/score_keeper.sv
logic/naval_engine.sv
testbench/tb_naval_engine.sv

// File: logic/grid_store.sv
module grid_store import naval_pkg::*; (
	input  logic        clk_in,
	input  logic        BTN_RESET,
	input  turn_t       turn,
	input  fleet_load_t fleet_load,
	input  coord_t      rd_addr,
	input  logic        wr_en,
	input  coord_t      wr_addr,
	input  cell_t       wr_cell,
	output cell_t       rd_cell
);

	cell_t mem [CELL_COUNT];  // shared grid, one entry per cell
	logic  load_en;
	logic  [CELL_ADDR_W-1:0] load_addr;

	assign load_en   = fleet_load.valid && (turn == TURN_SETUP); // loads only count in setup
	assign load_addr = coord_to_addr(fleet_load.target);

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (BTN_RESET) begin
			for (int i = 0; i < CELL_COUNT; i++) begin
				mem[i] <= '0;  // empty sea, nothing fired
			end
		end else begin
			if (load_en) begin
				if (fleet_load.owner == SIDE_PLAYER) begin
					mem[load_addr].player_ship <= 1'b1;  // merge, other flags kept
				end else begin
					mem[load_addr].ai_ship <= 1'b1;
				end
			end
			if (wr_en) mem[coord_to_addr(wr_addr)] <= wr_cell;  // shot write-back
		end
	end

	// registered read, data one cycle after address
	always_ff @(posedge clk_in) begin
		rd_cell <= mem[coord_to_addr(rd_addr)];
	end

endmodule

// File: logic/naval_engine.sv
module naval_engine import naval_pkg::*; (
	input  logic                 clk_in,
	input  logic                 BTN_RESET,
	input  logic                 BTN_SOUTH,
	input  fleet_load_t          fleet_load,
	input  logic                 player_valid,
	input  coord_t               player_target,
	output logic                 player_ready,
	output turn_t                turn,
	output shot_result_t         shot_result,
	output logic [HIT_CNT_W-1:0] player_hits,
	output logic [HIT_CNT_W-1:0] ai_hits,
	output winner_t              winner
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	logic      req_valid;  // sequencer to resolver
	logic      req_ready;
	shot_req_t shot_req;
	coord_t    rd_addr;    // resolver to grid
	cell_t     rd_cell;
	logic      wr_en;
	coord_t    wr_addr;
	cell_t     wr_cell;

	turn_sequencer u_seq (
		.clk_in, .BTN_RESET, .BTN_SOUTH,
		.player_valid, .player_target, .req_ready,
		.shot_result, .winner,
		.player_ready, .req_valid, .shot_req, .turn
	);

	grid_store u_grid (
		.clk_in, .BTN_RESET, .turn, .fleet_load,
		.rd_addr, .wr_en, .wr_addr, .wr_cell,
		.rd_cell
	);

	shot_resolver u_res (
		.clk_in, .BTN_RESET, .req_valid, .shot_req, .rd_cell,
		.req_ready, .rd_addr, .wr_en, .wr_addr, .wr_cell,
		.shot_result
	);

	score_keeper u_score (
		.clk_in, .BTN_RESET, .shot_result,
		.player_hits, .ai_hits, .winner
	);

endmodule

// File: logic/naval_pkg.sv
package naval_pkg;

	// --------------------------------------------------
	// grid geometry
	// --------------------------------------------------
	localparam int GRID_DIM    = 8;                    // cells per side
	localparam int COORD_W     = 3;                    // bits per coordinate
	localparam int CELL_COUNT  = GRID_DIM * GRID_DIM;  // 64 cells
	localparam int CELL_ADDR_W = $clog2(CELL_COUNT);   // flat cell index width

	// --------------------------------------------------
	// game rules and machine player
	// --------------------------------------------------
	localparam int HITS_TO_WIN    = 18;                    // ship cells per fleet
	localparam int HIT_CNT_W      = 5;                     // fits 0..31
	localparam int AI_WAIT_CYCLES = 8;                     // pause before each machine shot
	localparam int WAIT_CNT_W     = $clog2(AI_WAIT_CYCLES); // counts 0..AI_WAIT_CYCLES-1
	localparam int LFSR_W         = 16;
	localparam logic [LFSR_W-1:0] AI_LFSR_SEED = 16'hace1; // any nonzero value
	localparam logic [LFSR_W-1:0] AI_LFSR_TAPS = 16'hb400; // x^16+x^14+x^13+x^11, maximal

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	typedef struct packed {
		logic [COORD_W-1:0] x;  // column
		logic [COORD_W-1:0] y;  // row
	} coord_t;

	// one grid cell, both fleets share the grid
	typedef struct packed {
		logic player_ship;  // player ship sits here
		logic ai_ship;      // machine ship sits here
		logic player_shot;  // player has fired here
		logic ai_shot;      // machine has fired here
	} cell_t;

	typedef enum logic {SIDE_PLAYER, SIDE_AI} side_t;

	typedef enum logic [2:0] {
		TURN_SETUP,    // fleets loading
		TURN_PLAYER,   // waiting on player shot
		TURN_AI_WAIT,  // machine thinking delay
		TURN_AI,       // machine shot in progress
		TURN_OVER      // game finished, frozen until reset
	} turn_t;

	typedef struct packed {
		coord_t target;
		side_t  shooter;
	} shot_req_t;

	typedef enum logic [1:0] {OUT_MISS, OUT_HIT, OUT_REPEAT} shot_outcome_t;

	typedef struct packed {
		logic          valid;    // one-cycle strobe
		side_t         shooter;
		coord_t        target;
		shot_outcome_t outcome;
	} shot_result_t;

	typedef struct packed {
		logic   valid;
		coord_t target;
		side_t  owner;  // whose ship goes into the cell
	} fleet_load_t;

	typedef enum logic [1:0] {WIN_NONE, WIN_PLAYER, WIN_AI} winner_t;

	// row-major flat index of a cell
	function automatic logic [CELL_ADDR_W-1:0] coord_to_addr(coord_t c);
		return {c.y, c.x};
	endfunction

endpackage

// File: logic/score_keeper.sv
module score_keeper import naval_pkg::*; (
	input  logic                 clk_in,
	input  logic                 BTN_RESET,
	input  shot_result_t         shot_result,
	output logic [HIT_CNT_W-1:0] player_hits,
	output logic [HIT_CNT_W-1:0] ai_hits,
	output winner_t              winner
);

	logic hit;

	assign hit = shot_result.valid && (shot_result.outcome == OUT_HIT);

	// --------------------------------------------------
	// hit counters and end of game
	// --------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (BTN_RESET) begin
			player_hits <= '0;
			ai_hits     <= '0;
			winner      <= WIN_NONE;
		end else if (winner == WIN_NONE) begin  // all frozen once decided
			if (player_hits >= HIT_CNT_W'(HITS_TO_WIN)) begin
				winner <= WIN_PLAYER;  // registered a cycle after the count
			end else if (ai_hits >= HIT_CNT_W'(HITS_TO_WIN)) begin
				winner <= WIN_AI;
			end
			if (hit) begin
				if (shot_result.shooter == SIDE_PLAYER) begin
					player_hits <= player_hits + 1'b1;
				end else begin
					ai_hits <= ai_hits + 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/shot_resolver.sv
module shot_resolver import naval_pkg::*; (
	input  logic         clk_in,
	input  logic         BTN_RESET,
	input  logic         req_valid,
	input  shot_req_t    shot_req,
	input  cell_t        rd_cell,
	output logic         req_ready,
	output coord_t       rd_addr,
	output logic         wr_en,
	output coord_t       wr_addr,
	output cell_t        wr_cell,
	output shot_result_t shot_result
);

	typedef enum logic [1:0] {
		RES_IDLE,    // ready for a request
		RES_READ,    // cell address presented to the grid
		RES_DECIDE   // cell data back, resolve and write
	} res_state_t;

	res_state_t    state;
	shot_req_t     req_q;      // request in flight
	logic          own_shot;   // shooter already fired here
	logic          opp_ship;   // opponent ship in the cell
	cell_t         new_cell;
	shot_outcome_t outcome;
	logic          decide;

	assign req_ready = (state == RES_IDLE);  // one shot in flight at a time
	assign decide    = (state == RES_DECIDE);
	assign rd_addr   = req_q.target;

	// --------------------------------------------------
	// shot rules
	// --------------------------------------------------
	always_comb begin
		new_cell = rd_cell;
		if (req_q.shooter == SIDE_PLAYER) begin
			own_shot             = rd_cell.player_shot;
			opp_ship             = rd_cell.ai_ship;
			new_cell.player_shot = 1'b1;
		end else begin
			own_shot         = rd_cell.ai_shot;
			opp_ship         = rd_cell.player_ship;
			new_cell.ai_shot = 1'b1;
		end
		if (own_shot) outcome = OUT_REPEAT;     // nothing written
		else if (opp_ship) outcome = OUT_HIT;
		else outcome = OUT_MISS;
	end

	// write-back lands on the same edge as the result strobe
	assign wr_en   = decide && !own_shot;
	assign wr_addr = req_q.target;
	assign wr_cell = new_cell;

	// --------------------------------------------------
	// FSM and result register
	// --------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (BTN_RESET) begin
			state             <= RES_IDLE;
			shot_result.valid <= 1'b0;
		end else begin
			shot_result.valid <= decide;  // single-cycle strobe
			unique case (state)
				RES_IDLE: begin
					if (req_valid) begin
						req_q <= shot_req;
						state <= RES_READ;
					end
				end
				RES_READ: state <= RES_DECIDE;  // grid latches rd_addr here
				RES_DECIDE: begin
					shot_result.shooter <= req_q.shooter;
					shot_result.target  <= req_q.target;
					shot_result.outcome <= outcome;
					state               <= RES_IDLE;
				end
				default: state <= RES_IDLE;
			endcase
		end
	end

endmodule

// File: logic/turn_sequencer.sv
module turn_sequencer import naval_pkg::*; (
	input  logic         clk_in,
	input  logic         BTN_RESET,
	input  logic         BTN_SOUTH,     // start button
	input  logic         player_valid,
	input  coord_t       player_target,
	input  logic         req_ready,
	input  shot_result_t shot_result,
	input  winner_t      winner,
	output logic         player_ready,
	output logic         req_valid,
	output shot_req_t    shot_req,
	output turn_t        turn
);

	logic [LFSR_W-1:0]     lfsr;      // free-running target source
	logic [WAIT_CNT_W-1:0] wait_cnt;  // machine thinking delay
	logic                  ai_valid;  // machine request pending
	logic                  busy;      // request accepted, result not seen yet
	shot_req_t             ai_req;    // held machine request
	coord_t                lfsr_target;
	logic                  req_fire;
	logic                  player_res;
	logic                  ai_res;

	// --------------------------------------------------
	// request side
	// --------------------------------------------------
	assign player_ready = (turn == TURN_PLAYER) && !busy && (winner == WIN_NONE);
	assign req_valid    = (player_valid && player_ready) || ai_valid;  // player passes straight through
	assign shot_req     = (turn == TURN_PLAYER) ? '{target: player_target, shooter: SIDE_PLAYER}
	                                            : ai_req;
	assign req_fire     = req_valid && req_ready;

	assign player_res  = shot_result.valid && (shot_result.shooter == SIDE_PLAYER);
	assign ai_res      = shot_result.valid && (shot_result.shooter == SIDE_AI);
	assign lfsr_target = '{x: lfsr[COORD_W-1:0], y: lfsr[2*COORD_W-1:COORD_W]};

	// galois lfsr, steps every cycle
	always_ff @(posedge clk_in) begin
		if (BTN_RESET) begin
			lfsr <= AI_LFSR_SEED;
		end else begin
			lfsr <= {1'b0, lfsr[LFSR_W-1:1]} ^ (lfsr[0] ? AI_LFSR_TAPS : '0);
		end
	end

	// --------------------------------------------------
	// turn FSM
	// --------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (BTN_RESET) begin
			turn     <= TURN_SETUP;
			wait_cnt <= '0;
			ai_valid <= 1'b0;
			busy     <= 1'b0;
		end else begin
			if (shot_result.valid) busy <= 1'b0;        // shot done
			if (req_fire) busy <= 1'b1;                 // never same cycle as a result
			if (ai_valid && req_ready) ai_valid <= 1'b0; // machine request taken

			unique case (turn)
				TURN_SETUP: begin
					if (BTN_SOUTH) turn <= TURN_PLAYER;
				end
				TURN_PLAYER: begin
					if (player_res && shot_result.outcome != OUT_REPEAT) begin // repeat keeps the turn
						turn     <= TURN_AI_WAIT;
						wait_cnt <= '0;
					end
				end
				TURN_AI_WAIT: begin
					if (wait_cnt == WAIT_CNT_W'(AI_WAIT_CYCLES - 1)) begin
						turn     <= TURN_AI;
						ai_valid <= 1'b1;
						ai_req   <= '{target: lfsr_target, shooter: SIDE_AI};
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				TURN_AI: begin
					if (ai_res) begin
						if (shot_result.outcome == OUT_REPEAT) begin // already shot, draw again
							ai_valid <= 1'b1;
							ai_req   <= '{target: lfsr_target, shooter: SIDE_AI};
						end else begin
							turn <= TURN_PLAYER;
						end
					end
				end
				TURN_OVER: ; // stays here until reset
				default: turn <= TURN_SETUP;
			endcase

			// game over overrides everything
			if (winner != WIN_NONE) begin
				turn     <= TURN_OVER;
				ai_valid <= 1'b0;
				busy     <= 1'b0;
			end
		end
	end

endmodule

// File: testbench/tb_naval_engine.sv
module tb_naval_engine import naval_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_TURNS      = 60;   // player turns, repeats included
	localparam int TURN_BUDGET    = 320;  // machine wait, retries and latency per turn
	localparam int TIMEOUT_CYCLES = MAX_TURNS * TURN_BUDGET + 800;  // plus reset and fleet load
	localparam logic [16:0] RESET_EXP = {TURN_SETUP, 1'b0, 1'b0, 5'd0, 5'd0, WIN_NONE};

	logic                 clk_in = 1'b0;
	logic                 BTN_RESET;
	logic                 BTN_SOUTH;
	fleet_load_t          fleet_load;
	logic                 player_valid;
	coord_t               player_target;
	logic                 player_ready;
	turn_t                turn;
	shot_result_t         shot_result;
	logic [HIT_CNT_W-1:0] player_hits;
	logic [HIT_CNT_W-1:0] ai_hits;
	winner_t              winner;

	cell_t                model [CELL_COUNT];  // reference grid
	logic [HIT_CNT_W-1:0] model_player_hits;
	logic [HIT_CNT_W-1:0] model_ai_hits;
	cell_t                res_cell;            // model cell under the current result
	shot_outcome_t        exp_outcome;
	coord_t               fired_target;        // target of the last accepted player shot
	int                   cycle_cnt  = 0;
	int                   accept_age = 0;      // cycles since the last accepted player shot

	naval_engine UUT (.*);

	always #10 clk_in = ~clk_in;  // 20 ns period

	function automatic int cell_index(coord_t c);
		return c.y * GRID_DIM + c.x;
	endfunction

	// own shot flag first, then the opponent's ship
	function automatic shot_outcome_t rule_outcome(cell_t c, side_t s);
		logic own_shot;
		logic opp_ship;
		own_shot = (s == SIDE_PLAYER) ? c.player_shot : c.ai_shot;
		opp_ship = (s == SIDE_PLAYER) ? c.ai_ship : c.player_ship;
		if (own_shot) return OUT_REPEAT;
		return opp_ship ? OUT_HIT : OUT_MISS;
	endfunction

	task automatic stop_run(string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at cycle %0d", cycle_cnt);
	endtask

	task automatic value_error(string test, longint expected, longint actual);
		stop_run($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
	endtask

	task automatic load_cell(input coord_t c, input side_t owner);
		@(posedge clk_in);
		fleet_load <= '{valid: 1'b1, target: c, owner: owner};
	endtask

	// waits for the player's turn, then offers one shot until it is taken
	task automatic fire_shot(input coord_t t, output logic over);
		do begin
			@(posedge clk_in);
		end while (!player_ready && turn != TURN_OVER);
		over = !player_ready;
		if (!over) begin
			player_valid  <= 1'b1;
			player_target <= t;
			@(posedge clk_in);  // ready holds until the request is taken
			player_valid <= 1'b0;
		end
	endtask

	// --------------------------------------------------
	// reference model and cycle bookkeeping
	// --------------------------------------------------
	assign res_cell    = model[cell_index(shot_result.target)];
	assign exp_outcome = rule_outcome(res_cell, shot_result.shooter);

	always @(posedge clk_in) begin
		if (BTN_RESET) begin
			for (int i = 0; i < CELL_COUNT; i++) begin
				model[i] <= '0;
			end
			model_player_hits <= '0;
			model_ai_hits     <= '0;
		end else begin
			if (fleet_load.valid && turn == TURN_SETUP) begin  // loads count only in setup
				if (fleet_load.owner == SIDE_PLAYER)
					model[cell_index(fleet_load.target)].player_ship <= 1'b1;
				else
					model[cell_index(fleet_load.target)].ai_ship <= 1'b1;
			end
			if (shot_result.valid && exp_outcome != OUT_REPEAT) begin  // repeat writes nothing
				if (shot_result.shooter == SIDE_PLAYER) begin
					model[cell_index(shot_result.target)].player_shot <= 1'b1;
					if (exp_outcome == OUT_HIT) model_player_hits <= model_player_hits + 1'b1;
				end else begin
					model[cell_index(shot_result.target)].ai_shot <= 1'b1;
					if (exp_outcome == OUT_HIT) model_ai_hits <= model_ai_hits + 1'b1;
				end
			end
		end
	end

	always @(posedge clk_in) begin
		cycle_cnt  <= cycle_cnt + 1;
		accept_age <= (player_valid && player_ready) ? 0 : accept_age + 1;
		if (player_valid && player_ready) fired_target <= player_target;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_run($sformatf("timeout: game did not end within %0d cycles", TIMEOUT_CYCLES));
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	assert property (@(posedge clk_in) $fell(BTN_RESET) |->
			{turn, player_ready, shot_result.valid, player_hits, ai_hits, winner} == RESET_EXP)
		else value_error("reset state", RESET_EXP, $sampled({turn, player_ready,
			shot_result.valid, player_hits, ai_hits, winner}));

	// result registered on the second edge after acceptance
	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.shooter == SIDE_PLAYER |-> accept_age == 2)
		else value_error("player shot latency", 2, $sampled(accept_age));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.shooter == SIDE_PLAYER
			|-> shot_result.target == fired_target)
		else value_error("player shot target", $sampled(fired_target),
			$sampled(shot_result.target));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid |-> shot_result.outcome == exp_outcome)
		else value_error("shot outcome", $sampled(exp_outcome), $sampled(shot_result.outcome));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.shooter == SIDE_PLAYER
			&& shot_result.outcome != OUT_REPEAT |=> turn == TURN_AI_WAIT)
		else value_error("turn after player shot", TURN_AI_WAIT, $sampled(turn));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.shooter == SIDE_PLAYER
			&& shot_result.outcome == OUT_REPEAT |=> turn == TURN_PLAYER)
		else value_error("turn after repeated shot", TURN_PLAYER, $sampled(turn));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.outcome == OUT_REPEAT
			|=> $stable(player_hits) && $stable(ai_hits))
		else value_error("counters after repeated shot",
			$sampled({model_player_hits, model_ai_hits}), $sampled({player_hits, ai_hits}));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.shooter == SIDE_AI
			&& shot_result.outcome != OUT_REPEAT |-> !res_cell.ai_shot)
		else value_error("machine fired on its own shot cell", 0, $sampled(res_cell.ai_shot));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			shot_result.valid && shot_result.shooter == SIDE_AI
			&& shot_result.outcome != OUT_REPEAT |=> turn == TURN_PLAYER)
		else value_error("turn after machine shot", TURN_PLAYER, $sampled(turn));

	assert property (@(posedge clk_in) disable iff (BTN_RESET) player_hits == model_player_hits)
		else value_error("player hit counter", $sampled(model_player_hits), $sampled(player_hits));

	assert property (@(posedge clk_in) disable iff (BTN_RESET) ai_hits == model_ai_hits)
		else value_error("machine hit counter", $sampled(model_ai_hits), $sampled(ai_hits));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			$rose(model_player_hits == HITS_TO_WIN) |=> winner == WIN_PLAYER)
		else value_error("winner", WIN_PLAYER, $sampled(winner));

	assert property (@(posedge clk_in) disable iff (BTN_RESET)
			$rose(model_player_hits == HITS_TO_WIN) |-> ##2 turn == TURN_OVER)
		else value_error("turn at game end", TURN_OVER, $sampled(turn));

	assert property (@(posedge clk_in) disable iff (BTN_RESET) turn == TURN_OVER |-> !player_ready)
		else value_error("player ready after game end", 0, $sampled(player_ready));

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		coord_t ai_fleet [HITS_TO_WIN];
		coord_t target;
		int     ship_idx;
		logic   game_over;
		void'($urandom(32'hd69c1bda));
		BTN_RESET     <= 1'b1;
		BTN_SOUTH     <= 1'b0;
		fleet_load    <= '0;
		player_valid  <= 1'b0;
		player_target <= '0;
		repeat (8) @(posedge clk_in);
		BTN_RESET <= 1'b0;

		for (int i = 0; i < HITS_TO_WIN; i++) begin
			ai_fleet[i] = '{x: COORD_W'(i % GRID_DIM), y: COORD_W'(i / GRID_DIM)};  // rows 0, 1, part of 2
			load_cell(ai_fleet[i], SIDE_AI);
		end
		for (int i = 4; i < GRID_DIM; i++) begin
			load_cell('{x: COORD_W'(i), y: 3'd5}, SIDE_PLAYER);  // four cells, machine cannot win
		end
		@(posedge clk_in);
		fleet_load <= '0;
		BTN_SOUTH  <= 1'b1;
		@(posedge clk_in);
		BTN_SOUTH <= 1'b0;

		target = '{x: COORD_W'($urandom), y: 3'd6};  // row 6 holds no ships
		fire_shot(target, game_over);
		fire_shot(target, game_over);  // same cell, repeat

		ship_idx = 0;
		while (!game_over) begin
			if (ship_idx < HITS_TO_WIN && $urandom_range(2) != 0) begin
				target = ai_fleet[ship_idx];
				ship_idx++;
			end else begin
				target = '{x: COORD_W'($urandom), y: COORD_W'($urandom)};  // anywhere
			end
			fire_shot(target, game_over);
		end

		assert (winner == WIN_PLAYER)
			else value_error("winner at end of run", WIN_PLAYER, winner);
		player_valid <= 1'b1;  // late shot, must never be taken
		repeat (4) @(posedge clk_in);
		player_valid <= 1'b0;
		@(negedge clk_in);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
